// ==== mipsPkg.sv ====
// Shared widths, memory depth, opcode and ALU encodings for the pipelined MIPS core, by scoped name
package mipsPkg;

	// Data and instruction word
	typedef logic [31:0] wordT;

	// Register index
	typedef logic [4:0] regAddrT;

	// Word index into unified memory, byte address bits 9 to 2
	typedef logic [7:0] memAddrT;

	// Unified memory size in words
	localparam int memDepth = 256;

	// Primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type function codes, instr[5:0]
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// Internal ALU operation select
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	// All-zero word, R-type with rd = 0, so it writes nothing visible
	localparam wordT nopWord = 32'h0000_0000;

endpackage

// ==== mipsRegFile.sv ====
// Decode-stage register file, 32 x 32 with two write-through read ports and $zero hardwired
`timescale 1ns/1ps

module mipsRegFile (
	input  logic            Clk,
	input  logic            rstN,
	input  mipsPkg::regAddrT readAddrA,
	input  mipsPkg::regAddrT readAddrB,
	input  mipsPkg::regAddrT writeAddr,
	input  logic            writeEn,
	input  mipsPkg::wordT    writeData,
	output mipsPkg::wordT    readDataA,
	output mipsPkg::wordT    readDataB
);

	mipsPkg::wordT regs [32];

	// Architectural state starts at zero
	// $zero is never written
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != 5'd0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Same-cycle writeback bypasses the array
	// Lets a consumer sit two slots behind its producer
	assign readDataA = (readAddrA == 5'd0) ? '0 :
		(writeEn && (writeAddr == readAddrA)) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == 5'd0) ? '0 :
		(writeEn && (writeAddr == readAddrB)) ? writeData : regs[readAddrB];

endmodule

// ==== mipsDecoder.sv ====
// Decode-stage control decoder, turns the fetched word into pipeline controls and a sign-extended immediate
`timescale 1ns/1ps

module mipsDecoder (
	input  mipsPkg::wordT instr,
	output logic         regWrite,
	output logic         memRead,
	output logic         memWrite,
	output logic         memToReg,
	output logic         aluSrcImm,
	output logic         regDstRd,
	output logic         branch,
	output mipsPkg::wordT immExt
);

	mipsPkg::opcodeT opcode;

	assign opcode = mipsPkg::opcodeT'(instr[31:26]);

	// 16-bit immediate, sign extended for ADDI, LW, SW and BEQ offset
	assign immExt = {{16{instr[15]}}, instr[15:0]};

	always_comb begin
		// Inactive unless the opcode is known
		regWrite  = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		memToReg  = 1'b0;
		aluSrcImm = 1'b0;
		regDstRd  = 1'b0;
		branch    = 1'b0;
		case (opcode)
			mipsPkg::opRType: begin
				// rd destination, both operands from registers
				regWrite = 1'b1;
				regDstRd = 1'b1;
			end
			mipsPkg::opAddi: begin
				regWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			mipsPkg::opLw: begin
				// Address = rs + imm, result from memory into rt
				regWrite  = 1'b1;
				memRead   = 1'b1;
				memToReg  = 1'b1;
				aluSrcImm = 1'b1;
			end
			mipsPkg::opSw: begin
				// rt carries the store data
				memWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			mipsPkg::opBeq: begin
				// Resolved in decode, nothing flows past
				branch = 1'b1;
			end
			default: begin
				// Unknown opcode behaves as a no-op
				regWrite = 1'b0;
			end
		endcase
	end

endmodule

// ==== mipsAlu.sv ====
// Execute-stage ALU, picks an operation from opcode and function code and computes the result
`timescale 1ns/1ps

module mipsAlu (
	input  mipsPkg::opcodeT opcode,
	input  mipsPkg::functT  funct,
	input  mipsPkg::wordT   operandA,
	input  mipsPkg::wordT   operandB,
	output mipsPkg::wordT   result
);

	mipsPkg::aluOpT aluOp;

	// Operation select
	always_comb begin
		case (opcode)
			mipsPkg::opRType: begin
				case (funct)
					mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
					default:        aluOp = mipsPkg::aluAdd;
				endcase
			end
			// Address and immediate sums
			mipsPkg::opAddi, mipsPkg::opLw, mipsPkg::opSw: aluOp = mipsPkg::aluAdd;
			default: aluOp = mipsPkg::aluAdd;
		endcase
	end

	always_comb begin
		case (aluOp)
			mipsPkg::aluSub: result = operandA - operandB;
			mipsPkg::aluAnd: result = operandA & operandB;
			mipsPkg::aluOr:  result = operandA | operandB;
			// Two's complement compare
			mipsPkg::aluSlt: result = {31'd0, $signed(operandA) < $signed(operandB)};
			default:         result = operandA + operandB;
		endcase
	end

endmodule

// ==== memArbiter.sv ====
// Fixed-priority arbiter that steers debug, data or fetch onto the single port of the unified memory
`timescale 1ns/1ps

module memArbiter (
	input  logic             dbgValid,
	input  logic             dbgWrite,
	input  mipsPkg::memAddrT dbgAddr,
	input  mipsPkg::wordT    dbgWdata,
	input  logic             dataReq,
	input  logic             dataWrite,
	input  mipsPkg::memAddrT dataAddr,
	input  mipsPkg::wordT    dataWdata,
	input  logic             fetchReq,
	input  mipsPkg::memAddrT fetchAddr,
	output logic             fetchGrant,
	output mipsPkg::memAddrT memAddr,
	output logic             memWe,
	output mipsPkg::wordT    memWdata
);

	// Fetch wins only when both others are idle
	assign fetchGrant = fetchReq && !dbgValid && !dataReq;

	always_comb begin
		if (dbgValid) begin
			memAddr  = dbgAddr;
			memWe    = dbgWrite;
			memWdata = dbgWdata;
		end else if (dataReq) begin
			memAddr  = dataAddr;
			memWe    = dataWrite;
			memWdata = dataWdata;
		end else begin
			// Fetch is read only
			memAddr  = fetchAddr;
			memWe    = 1'b0;
			memWdata = dataWdata;
		end
	end

endmodule

// ==== unifiedMemory.sv ====
// Unified instruction and data memory, one combinational read and one write per clock edge
`timescale 1ns/1ps

module unifiedMemory (
	input  logic             Clk,
	input  mipsPkg::memAddrT addr,
	input  logic             we,
	input  mipsPkg::wordT    wdata,
	output mipsPkg::wordT    rdata
);

	// Contents come from debug writes before run
	mipsPkg::wordT mem [mipsPkg::memDepth];

	always_ff @(posedge Clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Read shares the write address
	assign rdata = mem[addr];

endmodule

// ==== mipsFetch.sv ====
// Fetch stage with PC, next-PC select, branch flush and a bubble whenever the memory is not granted
`timescale 1ns/1ps

module mipsFetch (
	input  logic             Clk,
	input  logic             rstN,
	input  logic             run,
	input  logic             branchTaken,
	input  mipsPkg::wordT    branchTarget,
	input  logic             fetchGrant,
	input  mipsPkg::wordT    memRdata,
	output logic             fetchReq,
	output mipsPkg::memAddrT fetchAddr,
	output mipsPkg::wordT    instrId,
	output mipsPkg::wordT    pcPlus4Id
);

	mipsPkg::wordT pc;
	mipsPkg::wordT pcPlus4;
	logic          fetchOk;

	// Ask for the memory every cycle while running
	assign fetchReq  = run;
	assign fetchAddr = pc[9:2];
	assign pcPlus4   = pc + 32'd4;
	assign fetchOk   = fetchReq && fetchGrant;

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pc      <= '0;
			instrId <= mipsPkg::nopWord;
		end else begin
			// Branch redirect wins even on a denied cycle
			if (branchTaken) begin
				pc <= branchTarget;
			end else if (fetchOk) begin
				pc <= pcPlus4;
			end
			// Squash the slot behind a taken branch
			// Bubble when denied or stopped
			if (fetchOk && !branchTaken) begin
				instrId <= memRdata;
			end else begin
				instrId <= mipsPkg::nopWord;
			end
		end
	end

	// Only read with a real BEQ in decode
	always_ff @(posedge Clk) begin
		pcPlus4Id <= pcPlus4;
	end

endmodule

// ==== mipsTop.sv ====
// Top of the five-stage MIPS subset core, holds the stage registers and shares one memory with debug
`timescale 1ns/1ps

module mipsTop (
	input  logic             Clk,
	input  logic             rstN,
	input  logic             run,
	input  logic             dbgValid,
	input  logic             dbgWrite,
	input  mipsPkg::memAddrT dbgAddr,
	input  mipsPkg::wordT    dbgWdata,
	output mipsPkg::wordT    dbgRdata,
	output logic             wbValid,
	output mipsPkg::regAddrT wbReg,
	output mipsPkg::wordT    wbData
);

	// Memory path
	mipsPkg::memAddrT memAddr;
	logic             memWe;
	mipsPkg::wordT    memWdata;
	mipsPkg::wordT    memRdata;
	logic             fetchReq;
	logic             fetchGrant;
	mipsPkg::memAddrT fetchAddr;
	logic             dataReq;

	// Decode
	mipsPkg::wordT instrId;
	mipsPkg::wordT pcPlus4Id;
	mipsPkg::wordT readDataA;
	mipsPkg::wordT readDataB;
	mipsPkg::wordT immExtId;
	logic          regWriteId, memReadId, memWriteId, memToRegId;
	logic          aluSrcImmId, regDstRdId, branchId;
	logic          branchTaken;
	mipsPkg::wordT branchTarget;

	// Execute
	mipsPkg::wordT    instrEx;
	mipsPkg::wordT    readDataAEx;
	mipsPkg::wordT    readDataBEx;
	mipsPkg::wordT    immExtEx;
	logic             regWriteEx, memReadEx, memWriteEx, memToRegEx;
	logic             aluSrcImmEx, regDstRdEx;
	mipsPkg::wordT    aluOperandB;
	mipsPkg::wordT    aluResultEx;
	mipsPkg::regAddrT writeRegEx;

	// Memory
	logic             regWriteMem, memReadMem, memWriteMem, memToRegMem;
	mipsPkg::wordT    aluResultMem;
	mipsPkg::wordT    storeDataMem;
	mipsPkg::regAddrT writeRegMem;

	// Writeback
	logic             regWriteWb, memToRegWb;
	mipsPkg::wordT    aluResultWb;
	mipsPkg::wordT    loadDataWb;

	mipsFetch uFetch (
		.Clk          (Clk),
		.rstN         (rstN),
		.run          (run),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.fetchGrant   (fetchGrant),
		.memRdata     (memRdata),
		.fetchReq     (fetchReq),
		.fetchAddr    (fetchAddr),
		.instrId      (instrId),
		.pcPlus4Id    (pcPlus4Id)
	);

	mipsRegFile uRegFile (
		.Clk       (Clk),
		.rstN      (rstN),
		.readAddrA (instrId[25:21]),
		.readAddrB (instrId[20:16]),
		.writeAddr (wbReg),
		.writeEn   (regWriteWb),
		.writeData (wbData),
		.readDataA (readDataA),
		.readDataB (readDataB)
	);

	mipsDecoder uDecoder (
		.instr     (instrId),
		.regWrite  (regWriteId),
		.memRead   (memReadId),
		.memWrite  (memWriteId),
		.memToReg  (memToRegId),
		.aluSrcImm (aluSrcImmId),
		.regDstRd  (regDstRdId),
		.branch    (branchId),
		.immExt    (immExtId)
	);

	// BEQ resolves in decode, target = PC+4 + (imm << 2)
	assign branchTaken  = branchId && (readDataA == readDataB);
	assign branchTarget = pcPlus4Id + {immExtId[29:0], 2'b00};

	// ID/EX, BEQ and bubbles carry no controls forward
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			instrEx     <= mipsPkg::nopWord;
			regWriteEx  <= 1'b0;
			memReadEx   <= 1'b0;
			memWriteEx  <= 1'b0;
			memToRegEx  <= 1'b0;
			aluSrcImmEx <= 1'b0;
			regDstRdEx  <= 1'b0;
		end else begin
			instrEx     <= instrId;
			regWriteEx  <= regWriteId;
			memReadEx   <= memReadId;
			memWriteEx  <= memWriteId;
			memToRegEx  <= memToRegId;
			aluSrcImmEx <= aluSrcImmId;
			regDstRdEx  <= regDstRdId;
		end
	end

	always_ff @(posedge Clk) begin
		readDataAEx <= readDataA;
		readDataBEx <= readDataB;
		immExtEx    <= immExtId;
	end

	// rd for R-type, rt otherwise
	assign writeRegEx  = regDstRdEx ? instrEx[15:11] : instrEx[20:16];
	assign aluOperandB = aluSrcImmEx ? immExtEx : readDataBEx;

	mipsAlu uAlu (
		.opcode   (mipsPkg::opcodeT'(instrEx[31:26])),
		.funct    (mipsPkg::functT'(instrEx[5:0])),
		.operandA (readDataAEx),
		.operandB (aluOperandB),
		.result   (aluResultEx)
	);

	// EX/MEM
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			regWriteMem <= 1'b0;
			memReadMem  <= 1'b0;
			memWriteMem <= 1'b0;
			memToRegMem <= 1'b0;
		end else begin
			regWriteMem <= regWriteEx;
			memReadMem  <= memReadEx;
			memWriteMem <= memWriteEx;
			memToRegMem <= memToRegEx;
		end
	end

	always_ff @(posedge Clk) begin
		aluResultMem <= aluResultEx;
		storeDataMem <= readDataBEx;
		writeRegMem  <= writeRegEx;
	end

	// LW or SW in memory stage takes the port from fetch
	assign dataReq = memReadMem || memWriteMem;

	memArbiter uArbiter (
		.dbgValid   (dbgValid),
		.dbgWrite   (dbgWrite),
		.dbgAddr    (dbgAddr),
		.dbgWdata   (dbgWdata),
		.dataReq    (dataReq),
		.dataWrite  (memWriteMem),
		.dataAddr   (aluResultMem[9:2]),
		.dataWdata  (storeDataMem),
		.fetchReq   (fetchReq),
		.fetchAddr  (fetchAddr),
		.fetchGrant (fetchGrant),
		.memAddr    (memAddr),
		.memWe      (memWe),
		.memWdata   (memWdata)
	);

	unifiedMemory uMemory (
		.Clk   (Clk),
		.addr  (memAddr),
		.we    (memWe),
		.wdata (memWdata),
		.rdata (memRdata)
	);

	// Read word is shared by all requesters
	assign dbgRdata = memRdata;

	// MEM/WB
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			regWriteWb <= 1'b0;
			memToRegWb <= 1'b0;
		end else begin
			regWriteWb <= regWriteMem;
			memToRegWb <= memToRegMem;
		end
	end

	always_ff @(posedge Clk) begin
		aluResultWb <= aluResultMem;
		loadDataWb  <= memRdata;
		wbReg       <= writeRegMem;
	end

	// Retire trace, writes to $zero stay hidden
	assign wbData  = memToRegWb ? loadDataWb : aluResultWb;
	assign wbValid = regWriteWb && (wbReg != 5'd0);

endmodule

// ==== tbMipsTop.sv ====
// Testbench for mipsTop, loads the program from mipsPatterns.txt and checks retire trace and memory
`timescale 1ns/1ps

module tbMipsTop;

	// Cycles allowed for the pipeline to empty after the last retire
	localparam int drainCycles = 8;

	logic             Clk;
	logic             rstN;
	logic             run;
	logic             dbgValid;
	logic             dbgWrite;
	mipsPkg::memAddrT dbgAddr;
	mipsPkg::wordT    dbgWdata;
	mipsPkg::wordT    dbgRdata;
	logic             wbValid;
	mipsPkg::regAddrT wbReg;
	mipsPkg::wordT    wbData;

	// Pattern tables
	mipsPkg::memAddrT progAddr [$];
	mipsPkg::wordT    progWord [$];
	mipsPkg::regAddrT expReg [$];
	mipsPkg::wordT    expData [$];
	mipsPkg::memAddrT memAddrExp [$];
	mipsPkg::wordT    memDataExp [$];

	logic patternsLoaded;
	int   retireIdx;
	int   retireErrors;
	int   memErrors;
	int   otherErrors;

	mipsTop uut (
		.Clk      (Clk),
		.rstN     (rstN),
		.run      (run),
		.dbgValid (dbgValid),
		.dbgWrite (dbgWrite),
		.dbgAddr  (dbgAddr),
		.dbgWdata (dbgWdata),
		.dbgRdata (dbgRdata),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData)
	);

	// 20 ns clock
	initial begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	// Tag P, R or M, then two hex values; '#' starts a comment line
	task automatic loadPatterns();
		int                 fd;
		int                 code;
		byte                tag;
		logic [31:0]        first;
		logic [31:0]        second;
		logic [8*200-1:0]   skipLine;
		logic               atEnd;
		fd = $fopen("mipsPatterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file mipsPatterns.txt");
			otherErrors++;
		end else begin
			atEnd = 1'b0;
			while (!atEnd && !$feof(fd)) begin
				code = $fscanf(fd, " %c", tag);
				if (code != 1) begin
					atEnd = 1'b1;
				end else if (tag == "#") begin
					code = $fgets(skipLine, fd);
				end else begin
					code = $fscanf(fd, "%h %h", first, second);
					if (code != 2) begin
						$display("Malformed pattern line with tag %c", tag);
						otherErrors++;
					end else begin
						case (tag)
							"P": begin
								progAddr.push_back(first[7:0]);
								progWord.push_back(second);
							end
							"R": begin
								expReg.push_back(first[4:0]);
								expData.push_back(second);
							end
							"M": begin
								memAddrExp.push_back(first[7:0]);
								memDataExp.push_back(second);
							end
							default: begin
								$display("Unknown pattern tag %c", tag);
								otherErrors++;
							end
						endcase
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Debug write lands at the following edge
	task automatic debugWrite(input mipsPkg::memAddrT addr, input mipsPkg::wordT data);
		@(posedge Clk);
		dbgValid <= 1'b1;
		dbgWrite <= 1'b1;
		dbgAddr  <= addr;
		dbgWdata <= data;
	endtask

	// Read word is combinational, sampled mid-cycle
	task automatic debugRead(input mipsPkg::memAddrT addr, output mipsPkg::wordT data);
		@(posedge Clk);
		dbgValid <= 1'b1;
		dbgWrite <= 1'b0;
		dbgAddr  <= addr;
		@(negedge Clk);
		data = dbgRdata;
	endtask

	task automatic debugRelease();
		@(posedge Clk);
		dbgValid <= 1'b0;
		dbgWrite <= 1'b0;
	endtask

	task automatic checkRetire(input int idx, input mipsPkg::regAddrT wantReg,
			input mipsPkg::wordT wantData, input mipsPkg::regAddrT gotReg,
			input mipsPkg::wordT gotData);
		if (gotReg !== wantReg) begin
			$display("[FAIL] retire %0d wbReg expected %h got %h", idx, wantReg, gotReg);
			retireErrors++;
		end
		if (gotData !== wantData) begin
			$display("[FAIL] retire %0d wbData expected %h got %h", idx, wantData, gotData);
			retireErrors++;
		end
	endtask

	task automatic checkMem(input mipsPkg::memAddrT addr, input mipsPkg::wordT want,
			input mipsPkg::wordT got);
		if (got !== want) begin
			$display("[FAIL] dbgRdata at %h expected %h got %h", addr, want, got);
			memErrors++;
		end
	endtask

	task automatic reportCounts();
		$display("Errors: retire %0d, memory %0d, other %0d",
			retireErrors, memErrors, otherErrors);
	endtask

	// Retire monitor, in order against the R entries
	always @(negedge Clk) begin
		if (rstN === 1'b1 && wbValid === 1'b1) begin
			if (retireIdx >= expReg.size()) begin
				$display("Extra retire beyond the expected trace: reg %0d data %h", wbReg, wbData);
				otherErrors++;
			end else begin
				checkRetire(retireIdx, expReg[retireIdx], expData[retireIdx], wbReg, wbData);
			end
			retireIdx++;
		end
	end

	// Watchdog scaled to program length
	initial begin : watchdog
		int limit;
		wait (patternsLoaded === 1'b1);
		limit = 20 * progAddr.size() + 200;
		repeat (limit) @(posedge Clk);
		$display("Timeout after %0d cycles, %0d of %0d retires seen, the rest are missing",
			limit, retireIdx, expReg.size());
		otherErrors++;
		reportCounts();
		$display("Simulation FAILED");
		$finish;
	end

	initial begin : mainSequence
		mipsPkg::wordT readBack;
		rstN           = 1'b0;
		run            = 1'b0;
		dbgValid       = 1'b0;
		dbgWrite       = 1'b0;
		dbgAddr        = '0;
		dbgWdata       = '0;
		retireIdx      = 0;
		retireErrors   = 0;
		memErrors      = 0;
		otherErrors    = 0;
		patternsLoaded = 1'b0;
		loadPatterns();
		patternsLoaded = 1'b1;

		// No retire while reset holds the pipeline
		repeat (4) begin
			@(posedge Clk);
			@(negedge Clk);
			if (wbValid !== 1'b0) begin
				$display("[FAIL] wbValid expected 0 got %h during reset", wbValid);
				otherErrors++;
			end
		end
		@(posedge Clk);
		rstN <= 1'b1;

		// Program load, then read back every word
		foreach (progAddr[i]) begin
			debugWrite(progAddr[i], progWord[i]);
		end
		foreach (progAddr[i]) begin
			debugRead(progAddr[i], readBack);
			checkMem(progAddr[i], progWord[i], readBack);
		end
		debugRelease();

		@(posedge Clk);
		run <= 1'b1;

		// Retires counted by the monitor
		wait (retireIdx >= expReg.size());
		repeat (drainCycles) @(posedge Clk);
		run <= 1'b0;
		repeat (5) @(posedge Clk);

		// Final data memory
		foreach (memAddrExp[i]) begin
			debugRead(memAddrExp[i], readBack);
			checkMem(memAddrExp[i], memDataExp[i], readBack);
		end
		debugRelease();

		reportCounts();
		if (retireErrors == 0 && memErrors == 0 && otherErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== mipsPatterns.txt ====
# P <word addr> <instruction word>, R <reg> <value> in retire order
# M <word addr> <final memory word>, all values hex
P 00 20010005
P 01 2002FFFD
P 02 2003000C
P 03 20000007
P 04 00222020
P 05 00232822
P 06 00613024
P 07 00613825
P 08 0041402A
P 09 0022482A
P 0A 00015020
P 0B AC040100
P 0C AC050104
P 0D 8C0B0100
P 0E 8C0C0104
P 0F AC070108
P 10 200DFFFF
P 11 016C7020
P 12 102A0002
P 13 20100063
P 14 20110062
P 15 10220001
P 16 20120055
P 17 AC0E010C
P 18 20130007
P 19 024DA020
P 1A 1000FFFF
R 01 00000005
R 02 FFFFFFFD
R 03 0000000C
R 04 00000002
R 05 FFFFFFF9
R 06 00000004
R 07 0000000D
R 08 00000001
R 09 00000000
R 0A 00000005
R 0B 00000002
R 0C FFFFFFF9
R 0D FFFFFFFF
R 0E FFFFFFFB
R 12 00000055
R 13 00000007
R 14 00000054
M 40 00000002
M 41 FFFFFFF9
M 42 0000000D
M 43 FFFFFFFB
M 1A 1000FFFF

// ==== mipsPipe.f ====
mipsPkg.sv
mipsRegFile.sv
mipsDecoder.sv
mipsAlu.sv
memArbiter.sv
unifiedMemory.sv
mipsFetch.sv
mipsTop.sv
tbMipsTop.sv
